/* common/dlm_pkg.sv */
// DLM shared widths, bus opcodes, register map and response queue sizing
`default_nettype none

package dlm_pkg;

	localparam int dlm_data_w = 64;
	localparam int dlm_chk_w = 8;
	localparam int dlm_word_w = 72;
	localparam int dlm_addr_w = 9;
	localparam int dlm_depth = 512;

	// Hamming parity bits, also the width of a codeword bit index
	localparam int dlm_syn_w = 7;

	localparam logic [2:0] dlm_op_put = 3'd1;
	localparam logic [2:0] dlm_op_get = 3'd4;
	localparam logic [2:0] dlm_op_ack = 3'd0;
	localparam logic [2:0] dlm_op_ack_data = 3'd1;

	localparam int dlm_credits = 4;
	localparam int dlm_qptr_w = $clog2(dlm_credits);
	localparam int dlm_qcnt_w = $clog2(dlm_credits + 1);
	localparam logic [dlm_qptr_w-1:0] dlm_qlast = dlm_qptr_w'(dlm_credits - 1);

	localparam logic [2:0] dlm_reg_ctrl = 3'd0;
	localparam logic [2:0] dlm_reg_inject = 3'd1;
	localparam logic [2:0] dlm_reg_corr_cnt = 3'd2;
	localparam logic [2:0] dlm_reg_uncorr_cnt = 3'd3;
	localparam logic [2:0] dlm_reg_err_addr = 3'd4;

	localparam int dlm_ctrl_en_bit = 0;
	localparam int dlm_ctrl_arm_bit = 1;
	localparam int dlm_ctrl_dbl_bit = 2;
	localparam int dlm_inj_bit1_lsb = 8;

	localparam int dlm_reg_w = 32;
	localparam int dlm_cnt_w = 16;

	// Hamming position of data bit idx; powers of two are left to the parity bits
	function automatic logic [dlm_syn_w-1:0] dlm_data_pos(input int idx);
		int n;
		logic [dlm_syn_w-1:0] pos;
		n = 0;
		pos = '0;
		for (int p = 3; p < dlm_word_w; p++) begin
			if ((p & (p - 1)) != 0) begin
				if (n == idx)
					pos = dlm_syn_w'(p);
				n++;
			end
		end
		return pos;
	endfunction

endpackage

`default_nettype wire

/* common/dlm_if.sv */
// DLM request, response and ECC configuration interfaces
`default_nettype none

interface dlm_req_if;
	logic valid;
	logic write;
	logic [dlm_pkg::dlm_addr_w-1:0] addr;
	logic [dlm_pkg::dlm_data_w-1:0] data;

	modport source (output valid, write, addr, data);
	modport sink (input valid, write, addr, data);
endinterface

interface dlm_resp_if;
	logic valid;
	logic [2:0] opcode;
	logic [dlm_pkg::dlm_data_w-1:0] data;
	logic denied;

	// Push only, the queue never stalls the controller
	modport source (output valid, opcode, data, denied);
	modport sink (input valid, opcode, data, denied);
endinterface

interface dlm_cfg_if;
	logic ecc_en;
	logic inj_arm;
	logic inj_double;
	logic [dlm_pkg::dlm_syn_w-1:0] inj_bit0;
	logic [dlm_pkg::dlm_syn_w-1:0] inj_bit1;
	logic inj_done;
	logic err_corr;
	logic err_uncorr;
	logic [dlm_pkg::dlm_addr_w-1:0] err_addr;

	modport regs (
		output ecc_en, inj_arm, inj_double, inj_bit0, inj_bit1,
		input inj_done, err_corr, err_uncorr, err_addr
	);
	modport ctrl (
		input ecc_en, inj_arm, inj_double, inj_bit0, inj_bit1,
		output inj_done, err_corr, err_uncorr, err_addr
	);
endinterface

`default_nettype wire

/* dlm_ram/dlm_ecc_enc.sv */
// SECDED (72,64) check-bit generator in extended Hamming form
`default_nettype none

module dlm_ecc_enc (
	input wire logic [dlm_pkg::dlm_data_w-1:0] data,
	output logic [dlm_pkg::dlm_chk_w-1:0] check
);

	logic [dlm_pkg::dlm_syn_w-1:0] ham;

	// Each data bit feeds the parity bits named by its Hamming position
	always_comb begin
		ham = '0;
		for (int j = 0; j < dlm_pkg::dlm_data_w; j++) begin
			ham = ham ^ ({dlm_pkg::dlm_syn_w{data[j]}} & dlm_pkg::dlm_data_pos(j));
		end
	end

	// Top bit makes the whole codeword even
	assign check = {(^data) ^ (^ham), ham};

endmodule

`default_nettype wire

/* dlm_ram/dlm_ecc_dec.sv */
// SECDED (72,64) decoder with single-bit correction and double-bit detection
`default_nettype none

module dlm_ecc_dec (
	input wire logic [dlm_pkg::dlm_word_w-1:0] word,
	output logic [dlm_pkg::dlm_data_w-1:0] data,
	output logic single_err,
	output logic double_err
);

	logic [dlm_pkg::dlm_chk_w-1:0] recalc;
	logic [dlm_pkg::dlm_syn_w-1:0] syndrome;
	logic parity_err;

	dlm_ecc_enc u_enc (
		.data (word[dlm_pkg::dlm_data_w-1:0]),
		.check (recalc)
	);

	assign syndrome = recalc[dlm_pkg::dlm_syn_w-1:0] ^
		word[dlm_pkg::dlm_data_w +: dlm_pkg::dlm_syn_w];

	// Parity of all 72 stored bits, rebuilt from the recomputed check bits
	assign parity_err = recalc[dlm_pkg::dlm_chk_w-1] ^ word[dlm_pkg::dlm_word_w-1] ^
		(^syndrome);

	assign single_err = parity_err;
	assign double_err = !parity_err && (syndrome != '0);

	// Check-bit errors point at a power of two and leave data alone
	always_comb begin
		data = word[dlm_pkg::dlm_data_w-1:0];
		if (parity_err) begin
			for (int j = 0; j < dlm_pkg::dlm_data_w; j++) begin
				if (syndrome == dlm_pkg::dlm_data_pos(j))
					data[j] = !data[j];
			end
		end
	end

endmodule

`default_nettype wire

/* dlm_ram/dlm_sram.sv */
// Behavioural 512x72 single-port synchronous SRAM
`default_nettype none

module dlm_sram (
	input wire logic lm_clk,
	input wire logic en,
	input wire logic we,
	input wire logic [dlm_pkg::dlm_addr_w-1:0] addr,
	input wire logic [dlm_pkg::dlm_word_w-1:0] wdata,
	output logic [dlm_pkg::dlm_word_w-1:0] rdata
);

	logic [dlm_pkg::dlm_word_w-1:0] mem [dlm_pkg::dlm_depth];

	// Read data only moves on an enabled read
	always_ff @(posedge lm_clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

/* dlm_ram/dlm_ram_ctrl.sv */
// DLM memory controller with ECC encode, error injection and read decode
`default_nettype none

module dlm_ram_ctrl (
	input wire logic lm_clk,
	input wire logic lm_reset_n,
	dlm_req_if.sink req,
	dlm_resp_if.source resp,
	dlm_cfg_if.ctrl cfg
);

	logic [dlm_pkg::dlm_chk_w-1:0] wr_check;
	logic [dlm_pkg::dlm_word_w-1:0] inj_mask;
	logic [dlm_pkg::dlm_word_w-1:0] wr_word;
	logic [dlm_pkg::dlm_word_w-1:0] rd_word;
	logic [dlm_pkg::dlm_data_w-1:0] dec_data;
	logic single_err;
	logic double_err;
	logic inj_now;
	logic rd_valid_q;
	logic rd_write_q;
	logic [dlm_pkg::dlm_addr_w-1:0] rd_addr_q;

	dlm_ecc_enc u_enc (
		.data (req.data),
		.check (wr_check)
	);

	always_comb begin
		inj_mask = '0;
		for (int k = 0; k < dlm_pkg::dlm_word_w; k++) begin
			if (cfg.inj_bit0 == k || (cfg.inj_double && cfg.inj_bit1 == k))
				inj_mask[k] = 1'b1;
		end
	end

	// Only the first write after arming is corrupted
	assign inj_now = req.valid && req.write && cfg.inj_arm;
	assign wr_word = {wr_check, req.data} ^ (inj_mask & {dlm_pkg::dlm_word_w{inj_now}});

	dlm_sram u_sram (
		.lm_clk (lm_clk),
		.en (req.valid),
		.we (req.write),
		.addr (req.addr),
		.wdata (wr_word),
		.rdata (rd_word)
	);

	dlm_ecc_dec u_dec (
		.word (rd_word),
		.data (dec_data),
		.single_err (single_err),
		.double_err (double_err)
	);

	always_ff @(posedge lm_clk or negedge lm_reset_n) begin
		if (!lm_reset_n)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= req.valid;
	end

	// Follows the RAM read stage
	always_ff @(posedge lm_clk) begin
		if (req.valid) begin
			rd_write_q <= req.write;
			rd_addr_q <= req.addr;
		end
	end

	assign resp.valid = rd_valid_q;
	assign resp.opcode = rd_write_q ? dlm_pkg::dlm_op_ack : dlm_pkg::dlm_op_ack_data;

	always_comb begin
		if (rd_write_q)
			resp.data = '0;
		else if (cfg.ecc_en)
			resp.data = dec_data;
		else
			resp.data = rd_word[dlm_pkg::dlm_data_w-1:0];
	end

	assign resp.denied = !rd_write_q && cfg.ecc_en && double_err;

	assign cfg.inj_done = inj_now;
	assign cfg.err_corr = rd_valid_q && !rd_write_q && cfg.ecc_en && single_err;
	assign cfg.err_uncorr = rd_valid_q && !rd_write_q && cfg.ecc_en && double_err;
	assign cfg.err_addr = rd_addr_q;

endmodule

`default_nettype wire

/* design/dlm_resp_fifo.sv */
// DLM response queue feeding the D channel and returning A-side credits
`default_nettype none

module dlm_resp_fifo (
	input wire logic lm_clk,
	input wire logic lm_reset_n,
	dlm_resp_if.sink resp,
	output logic dlm_d_valid,
	output logic [2:0] dlm_d_opcode,
	output logic [dlm_pkg::dlm_data_w-1:0] dlm_d_data,
	output logic dlm_d_denied,
	input wire logic dlm_d_ready,
	output logic dlm_a_credit
);

	logic [2:0] q_opcode [dlm_pkg::dlm_credits];
	logic [dlm_pkg::dlm_data_w-1:0] q_data [dlm_pkg::dlm_credits];
	logic q_denied [dlm_pkg::dlm_credits];
	logic [dlm_pkg::dlm_qptr_w-1:0] wr_ptr;
	logic [dlm_pkg::dlm_qptr_w-1:0] rd_ptr;
	logic [dlm_pkg::dlm_qcnt_w-1:0] count;
	logic pop;

	assign pop = dlm_d_valid && dlm_d_ready;

	always_ff @(posedge lm_clk) begin
		if (resp.valid) begin
			q_opcode[wr_ptr] <= resp.opcode;
			q_data[wr_ptr] <= resp.data;
			q_denied[wr_ptr] <= resp.denied;
		end
	end

	always_ff @(posedge lm_clk or negedge lm_reset_n) begin
		if (!lm_reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			dlm_a_credit <= 1'b0;
		end else begin
			if (resp.valid)
				wr_ptr <= (wr_ptr == dlm_pkg::dlm_qlast) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == dlm_pkg::dlm_qlast) ? '0 : rd_ptr + 1'b1;
			case ({resp.valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// One credit back per response handed over
			dlm_a_credit <= pop;
		end
	end

	assign dlm_d_valid = (count != '0);
	assign dlm_d_opcode = q_opcode[rd_ptr];
	assign dlm_d_data = q_data[rd_ptr];
	assign dlm_d_denied = q_denied[rd_ptr];

endmodule

`default_nettype wire

/* design/dlm_ecc_regs.sv */
// ECC control, error injection and error counter registers
`default_nettype none

module dlm_ecc_regs (
	input wire logic lm_clk,
	input wire logic lm_reset_n,
	input wire logic reg_wr,
	input wire logic [2:0] reg_addr,
	input wire logic [dlm_pkg::dlm_reg_w-1:0] reg_wdata,
	output logic [dlm_pkg::dlm_reg_w-1:0] reg_rdata,
	dlm_cfg_if.regs cfg
);

	logic ecc_en_q;
	logic inj_arm_q;
	logic inj_double_q;
	logic [dlm_pkg::dlm_syn_w-1:0] inj_bit0_q;
	logic [dlm_pkg::dlm_syn_w-1:0] inj_bit1_q;
	logic [dlm_pkg::dlm_cnt_w-1:0] corr_cnt;
	logic [dlm_pkg::dlm_cnt_w-1:0] uncorr_cnt;
	logic [dlm_pkg::dlm_addr_w-1:0] err_addr_q;

	always_ff @(posedge lm_clk or negedge lm_reset_n) begin
		if (!lm_reset_n) begin
			ecc_en_q <= 1'b1;
			inj_arm_q <= 1'b0;
			inj_double_q <= 1'b0;
			inj_bit0_q <= '0;
			inj_bit1_q <= '0;
			corr_cnt <= '0;
			uncorr_cnt <= '0;
			err_addr_q <= '0;
		end else begin
			// A fresh ctrl write wins over the injection completing
			if (reg_wr && reg_addr == dlm_pkg::dlm_reg_ctrl) begin
				ecc_en_q <= reg_wdata[dlm_pkg::dlm_ctrl_en_bit];
				inj_arm_q <= reg_wdata[dlm_pkg::dlm_ctrl_arm_bit];
				inj_double_q <= reg_wdata[dlm_pkg::dlm_ctrl_dbl_bit];
			end else if (cfg.inj_done) begin
				inj_arm_q <= 1'b0;
			end
			if (reg_wr && reg_addr == dlm_pkg::dlm_reg_inject) begin
				inj_bit0_q <= reg_wdata[dlm_pkg::dlm_syn_w-1:0];
				inj_bit1_q <= reg_wdata[dlm_pkg::dlm_inj_bit1_lsb +: dlm_pkg::dlm_syn_w];
			end
			// Counters stick at all ones
			if (reg_wr && reg_addr == dlm_pkg::dlm_reg_corr_cnt)
				corr_cnt <= '0;
			else if (cfg.err_corr && corr_cnt != '1)
				corr_cnt <= corr_cnt + 1'b1;
			if (reg_wr && reg_addr == dlm_pkg::dlm_reg_uncorr_cnt)
				uncorr_cnt <= '0;
			else if (cfg.err_uncorr && uncorr_cnt != '1)
				uncorr_cnt <= uncorr_cnt + 1'b1;
			if (cfg.err_corr || cfg.err_uncorr)
				err_addr_q <= cfg.err_addr;
		end
	end

	assign cfg.ecc_en = ecc_en_q;
	assign cfg.inj_arm = inj_arm_q;
	assign cfg.inj_double = inj_double_q;
	assign cfg.inj_bit0 = inj_bit0_q;
	assign cfg.inj_bit1 = inj_bit1_q;

	always_comb begin
		reg_rdata = '0;
		case (reg_addr)
			dlm_pkg::dlm_reg_ctrl: begin
				reg_rdata[dlm_pkg::dlm_ctrl_en_bit] = ecc_en_q;
				reg_rdata[dlm_pkg::dlm_ctrl_arm_bit] = inj_arm_q;
				reg_rdata[dlm_pkg::dlm_ctrl_dbl_bit] = inj_double_q;
			end
			dlm_pkg::dlm_reg_inject: begin
				reg_rdata[dlm_pkg::dlm_syn_w-1:0] = inj_bit0_q;
				reg_rdata[dlm_pkg::dlm_inj_bit1_lsb +: dlm_pkg::dlm_syn_w] = inj_bit1_q;
			end
			dlm_pkg::dlm_reg_corr_cnt: reg_rdata[dlm_pkg::dlm_cnt_w-1:0] = corr_cnt;
			dlm_pkg::dlm_reg_uncorr_cnt: reg_rdata[dlm_pkg::dlm_cnt_w-1:0] = uncorr_cnt;
			dlm_pkg::dlm_reg_err_addr: reg_rdata[dlm_pkg::dlm_addr_w-1:0] = err_addr_q;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* design/dlm_top.sv */
// DLM top level joining the ECC memory controller, register block and response queue
`default_nettype none

module dlm_top (
	input wire logic lm_clk,
	input wire logic lm_reset_n,

	input wire logic dlm_a_valid,
	input wire logic [2:0] dlm_a_opcode,
	input wire logic [dlm_pkg::dlm_addr_w-1:0] dlm_a_addr,
	input wire logic [dlm_pkg::dlm_data_w-1:0] dlm_a_data,
	output logic dlm_a_credit,

	output logic dlm_d_valid,
	output logic [2:0] dlm_d_opcode,
	output logic [dlm_pkg::dlm_data_w-1:0] dlm_d_data,
	output logic dlm_d_denied,
	input wire logic dlm_d_ready,

	input wire logic reg_wr,
	input wire logic [2:0] reg_addr,
	input wire logic [dlm_pkg::dlm_reg_w-1:0] reg_wdata,
	output logic [dlm_pkg::dlm_reg_w-1:0] reg_rdata
);

	dlm_req_if req_if ();
	dlm_resp_if resp_if ();
	dlm_cfg_if cfg_if ();

	assign req_if.valid = dlm_a_valid;
	assign req_if.write = (dlm_a_opcode == dlm_pkg::dlm_op_put);
	assign req_if.addr = dlm_a_addr;
	assign req_if.data = dlm_a_data;

	dlm_ram_ctrl u_ram_ctrl (
		.lm_clk (lm_clk),
		.lm_reset_n (lm_reset_n),
		.req (req_if.sink),
		.resp (resp_if.source),
		.cfg (cfg_if.ctrl)
	);

	dlm_ecc_regs u_ecc_regs (
		.lm_clk (lm_clk),
		.lm_reset_n (lm_reset_n),
		.reg_wr (reg_wr),
		.reg_addr (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.cfg (cfg_if.regs)
	);

	dlm_resp_fifo u_resp_fifo (
		.lm_clk (lm_clk),
		.lm_reset_n (lm_reset_n),
		.resp (resp_if.sink),
		.dlm_d_valid (dlm_d_valid),
		.dlm_d_opcode (dlm_d_opcode),
		.dlm_d_data (dlm_d_data),
		.dlm_d_denied (dlm_d_denied),
		.dlm_d_ready (dlm_d_ready),
		.dlm_a_credit (dlm_a_credit)
	);

endmodule

`default_nettype wire

/* dv/dlm_tb_checks.svh */
// DLM testbench reference model for D responses and typed compare tasks
`ifndef DLM_TB_CHECKS_SVH
`define DLM_TB_CHECKS_SVH

typedef struct packed {
	logic [2:0] opcode;
	logic [dlm_pkg::dlm_data_w-1:0] data;
	logic denied;
} exp_resp_t;

// Expected response from the stored data and the flips made when it was written
function automatic exp_resp_t dlm_expect(
	input logic [2:0] opcode,
	input logic [dlm_pkg::dlm_data_w-1:0] stored,
	input logic ecc_en,
	input int nflips,
	input int bit0,
	input int bit1
);
	exp_resp_t r;
	logic [dlm_pkg::dlm_data_w-1:0] raw;
	raw = stored;
	if (nflips >= 1 && bit0 < dlm_pkg::dlm_data_w)
		raw[bit0] = ~raw[bit0];
	if (nflips == 2 && bit1 < dlm_pkg::dlm_data_w)
		raw[bit1] = ~raw[bit1];
	r.denied = 1'b0;
	if (opcode == dlm_pkg::dlm_op_put) begin
		r.opcode = dlm_pkg::dlm_op_ack;
		r.data = '0;
	end else begin
		r.opcode = dlm_pkg::dlm_op_ack_data;
		// Two flips cannot be corrected and pass through raw
		if (!ecc_en || nflips == 2)
			r.data = raw;
		else
			r.data = stored;
		r.denied = ecc_en && (nflips == 2);
	end
	return r;
endfunction

task automatic check_resp(
	input string what,
	input logic [2:0] got_opcode,
	input logic [dlm_pkg::dlm_data_w-1:0] got_data,
	input logic got_denied,
	input exp_resp_t exp
);
	if (got_opcode !== exp.opcode || got_data !== exp.data || got_denied !== exp.denied) begin
		$display("CHECK FAILED at %0t: %s got op %0d data %h denied %0b", $time, what,
			got_opcode, got_data, got_denied);
		$display("  expected op %0d data %h denied %0b", exp.opcode, exp.data, exp.denied);
		resp_errors++;
	end
endtask

task automatic check_reg(
	input string what,
	input logic [dlm_pkg::dlm_reg_w-1:0] got,
	input logic [dlm_pkg::dlm_reg_w-1:0] exp
);
	if (got !== exp) begin
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		reg_errors++;
	end
endtask

`endif

/* dv/dlm_tb.sv */
// DLM testbench driving the A channel and registers and checking D responses
`default_nettype none

module dlm_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int wait_limit = 2000;

	logic lm_clk = 1'b0;
	logic lm_reset_n = 1'b0;
	logic dlm_a_valid;
	logic [2:0] dlm_a_opcode;
	logic [dlm_pkg::dlm_addr_w-1:0] dlm_a_addr;
	logic [dlm_pkg::dlm_data_w-1:0] dlm_a_data;
	logic dlm_a_credit;
	logic dlm_d_valid;
	logic [2:0] dlm_d_opcode;
	logic [dlm_pkg::dlm_data_w-1:0] dlm_d_data;
	logic dlm_d_denied;
	logic dlm_d_ready = 1'b1;
	logic reg_wr;
	logic [2:0] reg_addr;
	logic [dlm_pkg::dlm_reg_w-1:0] reg_wdata;
	logic [dlm_pkg::dlm_reg_w-1:0] reg_rdata;

	int resp_errors = 0;
	int reg_errors = 0;

	`include "dlm_tb_checks.svh"

	exp_resp_t exp_q[$];
	int sent_count = 0;
	int returned_count = 0;
	int n_recv = 0;
	logic ready_random = 1'b0;

	// Memory model with the flips applied at write time
	logic [dlm_pkg::dlm_data_w-1:0] mdl_data [int];
	int mdl_flips [int];
	int mdl_bit0 [int];
	int mdl_bit1 [int];
	int written[$];

	logic m_ecc_en = 1'b1;
	logic m_arm = 1'b0;
	logic m_double = 1'b0;
	int m_bit0 = 0;
	int m_bit1 = 0;
	int corr_exp = 0;
	int uncorr_exp = 0;
	int err_addr_exp = 0;

	dlm_top dut_i (.*);

	always #4 lm_clk = ~lm_clk;

	always @(posedge lm_clk)
		dlm_d_ready <= ready_random ? 1'($urandom_range(1, 0)) : 1'b1;

	// Handshakes and credits are sampled mid-cycle, ahead of the edge they act on
	always @(negedge lm_clk) begin
		if (lm_reset_n) begin
			if (dlm_a_credit)
				returned_count++;
			if (returned_count > sent_count) begin
				$display("DUT returned more credits than were spent at %0t", $time);
				resp_errors++;
			end
			// A credit may only follow the response it frees
			if (returned_count > n_recv) begin
				$display("DUT returned a credit before its response was taken at %0t",
					$time);
				resp_errors++;
			end
			if (dlm_d_valid && dlm_d_ready) begin
				if (n_recv >= exp_q.size()) begin
					$display("DUT sent a response that no request asked for at %0t", $time);
					resp_errors++;
				end else begin
					check_resp($sformatf("response %0d", n_recv), dlm_d_opcode, dlm_d_data,
						dlm_d_denied, exp_q[n_recv]);
					n_recv++;
				end
			end
		end
	end

	task automatic report_counts();
		$display("Errors: %0d response, %0d register, %0d responses compared",
			resp_errors, reg_errors, n_recv);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		report_counts();
		$display("TEST FAIL");
		$finish;
	endtask

	function automatic logic [dlm_pkg::dlm_addr_w-1:0] random_addr();
		int unsigned r;
		r = $urandom_range(dlm_pkg::dlm_depth - 1, 0);
		return r[dlm_pkg::dlm_addr_w-1:0];
	endfunction

	function automatic logic [dlm_pkg::dlm_addr_w-1:0] random_written();
		int w;
		w = written[$urandom_range(written.size() - 1, 0)];
		return w[dlm_pkg::dlm_addr_w-1:0];
	endfunction

	function automatic logic [dlm_pkg::dlm_reg_w-1:0] ctrl_expect();
		logic [dlm_pkg::dlm_reg_w-1:0] v;
		v = '0;
		v[dlm_pkg::dlm_ctrl_en_bit] = m_ecc_en;
		v[dlm_pkg::dlm_ctrl_arm_bit] = m_arm;
		v[dlm_pkg::dlm_ctrl_dbl_bit] = m_double;
		return v;
	endfunction

	task automatic send_req(
		input logic [2:0] op,
		input logic [dlm_pkg::dlm_addr_w-1:0] addr,
		input logic [dlm_pkg::dlm_data_w-1:0] data
	);
		int waited;
		int a;
		a = int'(addr);
		waited = 0;
		@(posedge lm_clk);
		while (sent_count - returned_count >= dlm_pkg::dlm_credits) begin
			dlm_a_valid <= 1'b0;
			@(posedge lm_clk);
			waited++;
			if (waited > wait_limit)
				abort_run("Timed out waiting for the DUT to return a credit");
		end
		dlm_a_valid <= 1'b1;
		dlm_a_opcode <= op;
		dlm_a_addr <= addr;
		dlm_a_data <= data;
		sent_count++;
		if (op == dlm_pkg::dlm_op_put) begin
			mdl_data[a] = data;
			mdl_flips[a] = m_arm ? (m_double ? 2 : 1) : 0;
			mdl_bit0[a] = m_bit0;
			mdl_bit1[a] = m_bit1;
			m_arm = 1'b0;
			written.push_back(a);
			exp_q.push_back(dlm_expect(op, data, m_ecc_en, 0, 0, 0));
		end else begin
			exp_q.push_back(dlm_expect(op, mdl_data[a], m_ecc_en, mdl_flips[a], mdl_bit0[a],
				mdl_bit1[a]));
			if (m_ecc_en && mdl_flips[a] != 0) begin
				if (mdl_flips[a] == 1)
					corr_exp++;
				else
					uncorr_exp++;
				err_addr_exp = a;
			end
		end
	endtask

	task automatic drain_responses();
		int waited;
		waited = 0;
		@(posedge lm_clk);
		dlm_a_valid <= 1'b0;
		while (n_recv < exp_q.size()) begin
			@(posedge lm_clk);
			waited++;
			if (waited > wait_limit)
				abort_run("Timed out waiting for the outstanding D responses");
		end
	endtask

	task automatic wait_credits_idle();
		int waited;
		waited = 0;
		while (sent_count != returned_count) begin
			@(posedge lm_clk);
			waited++;
			if (waited > wait_limit)
				abort_run("Timed out waiting for all credits to come back");
		end
	endtask

	task automatic reg_write(input logic [2:0] addr, input logic [dlm_pkg::dlm_reg_w-1:0] data);
		@(posedge lm_clk);
		reg_wr <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
		@(posedge lm_clk);
		reg_wr <= 1'b0;
		case (addr)
			dlm_pkg::dlm_reg_ctrl: begin
				m_ecc_en = data[dlm_pkg::dlm_ctrl_en_bit];
				m_arm = data[dlm_pkg::dlm_ctrl_arm_bit];
				m_double = data[dlm_pkg::dlm_ctrl_dbl_bit];
			end
			dlm_pkg::dlm_reg_inject: begin
				m_bit0 = int'(data[6:0]);
				m_bit1 = int'(data[14:8]);
			end
			dlm_pkg::dlm_reg_corr_cnt: corr_exp = 0;
			dlm_pkg::dlm_reg_uncorr_cnt: uncorr_exp = 0;
			default: ;
		endcase
	endtask

	task automatic reg_read_check(
		input string what,
		input logic [2:0] addr,
		input logic [dlm_pkg::dlm_reg_w-1:0] exp
	);
		@(posedge lm_clk);
		reg_wr <= 1'b0;
		reg_addr <= addr;
		@(negedge lm_clk);
		check_reg(what, reg_rdata, exp);
	endtask

	task automatic check_counts(input string what);
		reg_read_check({what, " corrected count"}, dlm_pkg::dlm_reg_corr_cnt, 32'(corr_exp));
		reg_read_check({what, " uncorrectable count"}, dlm_pkg::dlm_reg_uncorr_cnt,
			32'(uncorr_exp));
	endtask

	initial begin
		logic [dlm_pkg::dlm_addr_w-1:0] addr;
		int b0;
		int b1;
		void'($urandom(32'hf4f49ab8));
		dlm_a_valid = 1'b0;
		dlm_a_opcode = '0;
		dlm_a_addr = '0;
		dlm_a_data = '0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		repeat (8) @(posedge lm_clk);
		lm_reset_n <= 1'b1;
		@(negedge lm_clk);
		check_reg("d_valid and a_credit after reset", {30'b0, dlm_d_valid, dlm_a_credit}, '0);
		reg_read_check("ctrl after reset", dlm_pkg::dlm_reg_ctrl, ctrl_expect());
		check_counts("reset");

		// Plain writes, then reads back
		repeat (16) send_req(dlm_pkg::dlm_op_put, random_addr(), {$urandom, $urandom});
		drain_responses();
		repeat (16) send_req(dlm_pkg::dlm_op_get, random_written(), '0);
		drain_responses();
		check_counts("clean reads");

		// Back-to-back traffic against a stalling D channel
		ready_random = 1'b1;
		for (int i = 0; i < 40; i++) begin
			if ($urandom_range(1, 0) == 1)
				send_req(dlm_pkg::dlm_op_put, random_addr(), {$urandom, $urandom});
			else
				send_req(dlm_pkg::dlm_op_get, random_written(), '0);
		end
		drain_responses();
		ready_random = 1'b0;
		wait_credits_idle();

		// Single-bit injection anywhere in the codeword
		addr = random_addr();
		b0 = $urandom_range(dlm_pkg::dlm_word_w - 1, 0);
		reg_write(dlm_pkg::dlm_reg_inject, 32'(b0));
		reg_write(dlm_pkg::dlm_reg_ctrl, 32'h3);
		send_req(dlm_pkg::dlm_op_put, addr, {$urandom, $urandom});
		drain_responses();
		reg_read_check("ctrl after single injection", dlm_pkg::dlm_reg_ctrl, ctrl_expect());
		send_req(dlm_pkg::dlm_op_get, addr, '0);
		drain_responses();
		check_counts("single injection");
		reg_read_check("error address", dlm_pkg::dlm_reg_err_addr, 32'(err_addr_exp));

		// Double injection at two distinct bits
		addr = random_addr();
		b0 = $urandom_range(dlm_pkg::dlm_word_w - 1, 0);
		b1 = (b0 + 1 + $urandom_range(dlm_pkg::dlm_word_w - 2, 0)) % dlm_pkg::dlm_word_w;
		reg_write(dlm_pkg::dlm_reg_inject, 32'(b0) | (32'(b1) << dlm_pkg::dlm_inj_bit1_lsb));
		reg_write(dlm_pkg::dlm_reg_ctrl, 32'h7);
		send_req(dlm_pkg::dlm_op_put, addr, {$urandom, $urandom});
		drain_responses();
		reg_read_check("ctrl after double injection", dlm_pkg::dlm_reg_ctrl, ctrl_expect());
		send_req(dlm_pkg::dlm_op_get, addr, '0);
		drain_responses();
		check_counts("double injection");
		reg_read_check("error address", dlm_pkg::dlm_reg_err_addr, 32'(err_addr_exp));

		// ECC off, so a flipped data bit comes back raw
		addr = random_addr();
		b0 = $urandom_range(dlm_pkg::dlm_data_w - 1, 0);
		reg_write(dlm_pkg::dlm_reg_inject, 32'(b0));
		reg_write(dlm_pkg::dlm_reg_ctrl, 32'h2);
		send_req(dlm_pkg::dlm_op_put, addr, {$urandom, $urandom});
		drain_responses();
		send_req(dlm_pkg::dlm_op_get, addr, '0);
		drain_responses();
		check_counts("ECC disabled");
		reg_write(dlm_pkg::dlm_reg_ctrl, 32'h1);

		reg_write(dlm_pkg::dlm_reg_corr_cnt, '0);
		reg_write(dlm_pkg::dlm_reg_uncorr_cnt, '0);
		check_counts("cleared");

		report_counts();
		if (resp_errors == 0 && reg_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
common/dlm_pkg.sv
common/dlm_if.sv
dlm_ram/dlm_ecc_enc.sv
dlm_ram/dlm_ecc_dec.sv
dlm_ram/dlm_sram.sv
dlm_ram/dlm_ram_ctrl.sv
design/dlm_resp_fifo.sv
design/dlm_ecc_regs.sv
design/dlm_top.sv
dv/dlm_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module dlm_tb \
	-f flist.f -o dlm_sim > sim.log 2>&1 &&
	./obj_dir/dlm_sim >> sim.log 2>&1 ||
	echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
